//--- list.f
+incdir+.
uart_pkg.sv
uartBaudGen.sv
uartRx.sv
byteFifo.sv
uartTx.sv
uartEcho.sv
uartEchoChecker.sv
tb_uartEcho.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_uartEcho -f list.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb_uartEcho.sv
`default_nettype none
`timescale 1ns/100ps
`include "uart_macros.svh"

module tb_uartEcho
    import uart_pkg::*;
();

    localparam int          CLK_PERIOD = 10;
    localparam int          BIT_CLKS   = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int          FIFO_DEPTH = 1 << `UART_FIFO_DEPTH_LOG2;
    localparam logic [31:0] LCG_SEED   = 32'h7d6e;
    localparam int          NUM_TESTS  = 6;
    localparam int          IDLE_BITS  = 20;
    localparam int          GUARD_BITS = 12;

    typedef struct packed {
        logic [7:0] count;
        logic [7:0] pattern;         // byte i is pattern + i
        logic       randomData;
        logic       badStop;         // first byte of the row only
        logic       holdTx;          // txEnable low while sending
        logic [7:0] expFrameErrors;
        logic       expOverflow;
    } testRow_t;

    logic        clk;
    logic        rst_n;
    logic        rx;
    logic        txEnable;
    logic        tx;
    uartStatus_t status;
    testRow_t    rows [NUM_TESTS];
    string       names [NUM_TESTS];
    logic [31:0] lcgState;

    uartEcho uartEcho_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .txEnable(txEnable),
        .tx      (tx),
        .status  (status)
    );

    uartEchoChecker checker_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tx    (tx),
        .status(status)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic driveLevel(input logic level, input int clocks);
        @(posedge clk);
        rx <= level;
        repeat (clocks - 1) @(posedge clk);
    endtask

    task automatic sendByte(input logic [7:0] b, input logic badStop);
        int i;
        driveLevel(1'b0, BIT_CLKS);
        for (i = 0; i < 8; i++) begin
            driveLevel(b[i], BIT_CLKS);  // lsb first
        end
        if (badStop) begin
            // held low past the mid-bit sample and then idle so rx can resync
            driveLevel(1'b0, BIT_CLKS * 3 / 4);
            driveLevel(1'b1, BIT_CLKS / 4 + 2 * BIT_CLKS);
        end else begin
            driveLevel(1'b1, BIT_CLKS);
        end
    endtask

    initial begin : clockGen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : stimulus
        int         r;
        int         i;
        int         drainWait;
        logic [7:0] b;
        testRow_t   row;
        //                   count  pattern rand  bad   hold  fe     ovf
        names[0] = "idle_after_reset";
        rows[0]  = '{8'd0,  8'h00, 1'b0, 1'b0, 1'b0, 8'd0, 1'b0};
        names[1] = "single_byte";
        rows[1]  = '{8'd1,  8'hA5, 1'b0, 1'b0, 1'b0, 8'd0, 1'b0};
        names[2] = "random_burst";
        rows[2]  = '{8'd8,  8'h00, 1'b1, 1'b0, 1'b0, 8'd0, 1'b0};
        names[3] = "bad_stop_bit";
        rows[3]  = '{8'd2,  8'h3C, 1'b0, 1'b1, 1'b0, 8'd1, 1'b0};
        names[4] = "overflow_hold";
        rows[4]  = '{8'd20, 8'h00, 1'b1, 1'b0, 1'b1, 8'd1, 1'b1};
        names[5] = "echo_after_overflow";
        rows[5]  = '{8'd4,  8'h00, 1'b1, 1'b0, 1'b0, 8'd1, 1'b1};

        rx       <= 1'b1;
        txEnable <= 1'b1;
        rst_n    <= 1'b0;
        lcgState = LCG_SEED;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (BIT_CLKS) @(posedge clk);

        for (r = 0; r < NUM_TESTS; r++) begin
            row = rows[r];
            checker_i.startTest(names[r]);
            txEnable <= !row.holdTx;
            for (i = 0; i < int'(row.count); i++) begin
                if (row.randomData) begin
                    lcgState = lcgNext(lcgState);
                    b = lcgState[23:16];
                end else begin
                    b = row.pattern + 8'(i);
                end
                // bad frames vanish and a held fifo keeps only its first entries
                if (!(row.badStop && i == 0) && (!row.holdTx || i < FIFO_DEPTH)) begin
                    checker_i.expectByte(b);
                end
                sendByte(b, row.badStop && i == 0);
            end
            if (row.count == 8'd0) begin
                repeat (IDLE_BITS * BIT_CLKS) @(posedge clk);
            end
            if (row.holdTx) begin
                @(posedge clk);
                txEnable <= 1'b1;
            end
            drainWait = 0;
            while (checker_i.pendingCount() != 0 &&
                   drainWait < (int'(row.count) + 2) * 12 * BIT_CLKS) begin
                @(posedge clk);
                drainWait++;
            end
            if (checker_i.pendingCount() != 0) begin
                checker_i.reportMissing();
            end
            repeat (GUARD_BITS * BIT_CLKS) @(posedge clk);  // catch stray frames
            @(negedge clk);
            checker_i.endTest(row.expFrameErrors, row.expOverflow);
            @(posedge clk);
        end

        checker_i.summary();
        if (checker_i.errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        int r;
        int totalBytes;
        int limit;
        @(posedge rst_n);
        totalBytes = 0;
        for (r = 0; r < NUM_TESTS; r++) begin
            totalBytes += int'(rows[r].count);
        end
        // each byte goes out and comes back plus idle and guard time per row
        limit = (totalBytes * 12 * 2 + NUM_TESTS * (IDLE_BITS + GUARD_BITS + 4)) * BIT_CLKS;
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d clocks", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- uartEchoChecker.sv
`default_nettype none
`timescale 1ns/100ps
`include "uart_macros.svh"

module uartEchoChecker
    import uart_pkg::*;
(
    input wire              clk,
    input wire              rst_n,
    input wire              tx,
    input wire uartStatus_t status
);

    localparam int BIT_CLKS = `UART_CLK_FREQ / `UART_BAUD_RATE;

    logic [7:0] expQ [$];   // bytes still owed on tx
    string      testName = "reset";
    int         testErrs = 0;
    int         errCount = 0;
    int         testsRun = 0;
    int         testsFailed = 0;

    task automatic flag(input string msg);
        $display("test %s: %s", testName, msg);
        testErrs++;
    endtask

    task automatic checkValue(input string what, input logic [7:0] expVal,
                              input logic [7:0] actVal);
        if (actVal !== expVal) begin
            $display("ERROR %s: %s expected 0x%02h, actual 0x%02h",
                     testName, what, expVal, actVal);
            testErrs++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
    endtask

    task automatic expectByte(input logic [7:0] b);
        expQ.push_back(b);
    endtask

    function automatic int pendingCount();
        return expQ.size();
    endfunction

    task automatic reportMissing();
        flag($sformatf("%0d expected byte(s) never came back on tx", expQ.size()));
        expQ.delete();
    endtask

    // status compare closes the test
    task automatic endTest(input logic [7:0] expFrameErrors, input logic expOverflow);
        checkValue("frameErrors", expFrameErrors, status.frameErrors);
        checkValue("overflow", {7'd0, expOverflow}, {7'd0, status.overflow});
        testsRun++;
        if (testErrs != 0) begin
            testsFailed++;
        end
        errCount += testErrs;
        $display("%s %s", (testErrs == 0) ? "PASS" : "FAIL", testName);
        testErrs = 0;
    endtask

    task automatic summary();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, errCount);
    endtask

    // rebuild each frame from tx, mid-bit samples on the falling clock edge
    initial begin : decodeTx
        logic       prevTx;
        logic [7:0] got;
        int         i;
        wait (rst_n === 1'b1);
        prevTx = 1'b1;
        forever begin
            @(negedge clk);
            if (prevTx === 1'b1 && tx === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge clk);  // middle of start bit
                if (tx !== 1'b0) begin
                    flag("start bit on tx did not stay low");
                end else begin
                    for (i = 0; i < 8; i++) begin
                        repeat (BIT_CLKS) @(negedge clk);
                        got[i] = tx;
                    end
                    repeat (BIT_CLKS) @(negedge clk);
                    checkValue("stop bit", 8'd1, {7'd0, tx});
                    if (expQ.size() == 0) begin
                        flag($sformatf("unexpected byte 0x%02h on tx", got));
                    end else begin
                        checkValue("echo byte", expQ.pop_front(), got);
                    end
                end
            end
            prevTx = tx;
        end
    end

endmodule

`default_nettype wire

//--- uartEcho.sv
`default_nettype none
`timescale 1ns/100ps

module uartEcho
    import uart_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         rx,
    input  wire         txEnable,
    output logic        tx,
    output uartStatus_t status
);

    baudTicks_t ticks;
    logic [7:0] rxByte;
    logic       rxValid;
    logic       frameError;
    logic [7:0] headByte;
    logic       full;
    logic       empty;
    logic       busy;
    logic       fifoWr;
    logic       pop;

    assign fifoWr = rxValid && !full;             // overflow bytes are dropped
    assign pop    = !empty && txEnable && !busy;  // also the tx load strobe

    uartBaudGen u_baudGen (
        .clk  (clk),
        .rst_n(rst_n),
        .ticks(ticks)
    );

    uartRx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .ticks     (ticks),
        .rx        (rx),
        .rxByte    (rxByte),
        .rxValid   (rxValid),
        .frameError(frameError)
    );

    byteFifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wrEn  (fifoWr),
        .wrData(rxByte),
        .rdEn  (pop),
        .rdData(headByte),
        .full  (full),
        .empty (empty)
    );

    uartTx u_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .ticks (ticks),
        .load  (pop),
        .txByte(headByte),
        .tx    (tx),
        .busy  (busy)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
        end else begin
            if (rxValid && full) begin
                status.overflow <= 1'b1;  // sticky until reset
            end
            if (frameError && status.frameErrors != 8'hFF) begin
                status.frameErrors <= status.frameErrors + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- uartTx.sv
`default_nettype none
`timescale 1ns/100ps

module uartTx
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  baudTicks_t ticks,
    input  wire        load,
    input  wire  [7:0] txByte,
    output logic       tx,
    output logic       busy
);

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] START = 2'd1;
    localparam logic [1:0] DATA  = 2'd2;
    localparam logic [1:0] STOP  = 2'd3;

    logic [1:0] state;
    logic [3:0] bitCnt;
    logic [7:0] txShift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            bitCnt <= '0;
            tx     <= 1'b1;
            busy   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    tx <= 1'b1;
                    if (load) begin
                        busy  <= 1'b1;
                        state <= START;  // wait for the next bit boundary
                    end
                end
                START: begin
                    if (ticks.bitTick) begin
                        tx     <= 1'b0;
                        bitCnt <= '0;
                        state  <= DATA;
                    end
                end
                DATA: begin
                    if (ticks.bitTick) begin
                        tx     <= txShift[0];  // ninth shift puts out the stop bit
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == 4'd8) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (ticks.bitTick) begin
                        busy  <= 1'b0;  // stop bit done
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // ones fill in from the top
    always_ff @(posedge clk) begin
        if (load && !busy) begin
            txShift <= txByte;
        end else if (state == DATA && ticks.bitTick) begin
            txShift <= {1'b1, txShift[7:1]};
        end
    end

    noLoadWhileBusy: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !busy)
        else $error("tx load while busy");

endmodule

`default_nettype wire

//--- byteFifo.sv
`default_nettype none
`timescale 1ns/100ps
`include "uart_macros.svh"

module byteFifo (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        wrEn,
    input  wire  [7:0] wrData,
    input  wire        rdEn,
    output logic [7:0] rdData,
    output logic       full,
    output logic       empty
);

    localparam int AW    = `UART_FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    logic [7:0]  mem [DEPTH];
    logic [AW:0] wrPtr;   // extra msb tells full from empty
    logic [AW:0] rdPtr;

    assign empty  = (wrPtr == rdPtr);
    assign full   = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);
    assign rdData = mem[rdPtr[AW-1:0]];  // head shown without a read cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (wrEn && !full) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (rdEn && !empty) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn && !full) begin
            mem[wrPtr[AW-1:0]] <= wrData;
        end
    end

    // the top level is expected to gate both strobes with the flags
    noWriteWhenFull: assert property (@(posedge clk) disable iff (!rst_n)
        wrEn |-> !full)
        else $error("fifo write while full");

    noReadWhenEmpty: assert property (@(posedge clk) disable iff (!rst_n)
        rdEn |-> !empty)
        else $error("fifo read while empty");

endmodule

`default_nettype wire

//--- uartRx.sv
`default_nettype none
`timescale 1ns/100ps
`include "uart_macros.svh"

module uartRx
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  baudTicks_t ticks,
    input  wire        rx,
    output logic [7:0] rxByte,
    output logic       rxValid,
    output logic       frameError
);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] DATA = 2'd1;
    localparam logic [1:0] STOP = 2'd2;

    localparam int          OVS_W       = $clog2(`UART_OVERSAMPLE);
    localparam logic [OVS_W-1:0] HALF_SAMPLE = OVS_W'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [OVS_W-1:0] LAST_SAMPLE = OVS_W'(`UART_OVERSAMPLE - 1);

    logic [1:0]       state;
    logic [OVS_W-1:0] sampleCnt;
    logic [2:0]       bitIdx;
    logic [1:0]       rxMeta;
    logic             rxSync;
    logic             bitSample;   // mid-bit sample point

    assign rxSync    = rxMeta[1];
    assign bitSample = ticks.sampleTick && (sampleCnt == LAST_SAMPLE);

    // line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxMeta <= 2'b11;
        end else begin
            rxMeta <= {rxMeta[0], rx};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            sampleCnt  <= '0;
            bitIdx     <= '0;
            rxValid    <= 1'b0;
            frameError <= 1'b0;
        end else begin
            rxValid    <= 1'b0;
            frameError <= 1'b0;
            case (state)
                IDLE: begin
                    if (ticks.sampleTick) begin
                        if (rxSync) begin
                            sampleCnt <= '0;  // glitch, start over
                        end else if (sampleCnt == HALF_SAMPLE) begin
                            sampleCnt <= '0;
                            bitIdx    <= '0;
                            state     <= DATA;
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (ticks.sampleTick) begin
                        sampleCnt <= sampleCnt + 1'b1;  // wraps to 0 at the sample point
                        if (bitSample) begin
                            bitIdx <= bitIdx + 1'b1;
                            if (bitIdx == 3'd7) begin
                                state <= STOP;
                            end
                        end
                    end
                end
                STOP: begin
                    if (ticks.sampleTick) begin
                        sampleCnt <= sampleCnt + 1'b1;
                        if (bitSample) begin
                            rxValid    <= rxSync;
                            frameError <= !rxSync;  // low stop bit, byte dropped
                            state      <= IDLE;
                        end
                    end
                end
                default: begin
                    state     <= IDLE;
                    sampleCnt <= '0;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == DATA && bitSample) begin
            rxByte <= {rxSync, rxByte[7:1]};
        end
    end

    validXorError: assert property (@(posedge clk) disable iff (!rst_n)
        !(rxValid && frameError))
        else $error("rxValid and frameError together");

endmodule

`default_nettype wire

//--- uartBaudGen.sv
`default_nettype none
`timescale 1ns/100ps
`include "uart_macros.svh"

module uartBaudGen
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    output baudTicks_t ticks
);

    localparam int SAMPLE_DIV = `UART_CLK_FREQ / (`UART_BAUD_RATE * `UART_OVERSAMPLE);
    localparam int DIV_W      = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
    localparam int OVS_W      = $clog2(`UART_OVERSAMPLE);

    logic [DIV_W-1:0] divCnt;
    logic [OVS_W-1:0] sampleCnt;   // sample ticks within the current bit
    logic             sampleDue;

    assign sampleDue = (divCnt == DIV_W'(SAMPLE_DIV - 1));

    // both strobes registered, so bitTick always rides on a sampleTick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            divCnt    <= '0;
            sampleCnt <= '0;
            ticks     <= '0;
        end else begin
            ticks.sampleTick <= sampleDue;
            ticks.bitTick    <= sampleDue && (sampleCnt == OVS_W'(`UART_OVERSAMPLE - 1));
            if (sampleDue) begin
                divCnt    <= '0;
                sampleCnt <= sampleCnt + 1'b1;  // wraps every 16
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

    // rx and tx both rely on the two strobes staying aligned
    bitOnSample: assert property (@(posedge clk) disable iff (!rst_n)
        ticks.bitTick |-> ticks.sampleTick)
        else $error("bitTick without sampleTick");

endmodule

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    // enable strobes from the baud generator
    typedef struct packed {
        logic sampleTick;   // 16x bit rate
        logic bitTick;      // lines up with every 16th sampleTick
    } baudTicks_t;

    // status seen at the top level
    typedef struct packed {
        logic       overflow;       // sticky
        logic [7:0] frameErrors;    // saturates at 255
    } uartStatus_t;

endpackage

`default_nettype wire

//--- uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// system clock in Hz
`define UART_CLK_FREQ 32_000_000

// serial rate, 32 clocks per bit at the default clock
`define UART_BAUD_RATE 1_000_000

// samples taken per bit by the receiver
`define UART_OVERSAMPLE 16

// fifo address width, 16 entries
`define UART_FIFO_DEPTH_LOG2 4

`endif
